//--- hw/pe_pkg.sv
package pe_pkg;

  // side info carried by every input beat
  typedef struct packed {
    // first beat of a new sum, clears the accumulator
    logic is_w_first;
    // last input channel, the result is due after this beat
    logic is_cin_last;
  } tuser_t;

  // control that rides along with a beat through the multiplier pipeline
  typedef struct packed {
    logic   valid;
    logic   last;
    tuser_t user;
  } beat_ctrl_t;

  // default array shape
  localparam int default_rows = 4;
  localparam int default_cols = 4;

  // default datapath widths
  localparam int default_x_bits = 8;
  localparam int default_k_bits = 8;
  // wide enough to sum many 16 bit products without overflow
  localparam int default_y_bits = 24;

  // multiplier latency in enabled cycles, input register included
  localparam int default_delay_mul = 3;

endpackage

//--- hw/n_delay.sv
`timescale 1ns/1ps

module n_delay #(
  parameter int n     = 1,
  parameter int width = 1
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             en,
  input  logic [width-1:0] d,
  output logic [width-1:0] q
);

  if (n == 0) begin : g_pass
    // zero depth, plain wire
    assign q = d;
  end else begin : g_chain
    // stage 0 takes d, stage n-1 drives q
    logic [n-1:0][width-1:0] stage;

    always_ff @(posedge clk) begin
      if (!resetn) begin
        stage <= '0;
      end else if (en) begin
        stage[0] <= d;
        // whole chain moves together, so a stalled column keeps its beats
        for (int i = 1; i < n; i++) begin
          stage[i] <= stage[i-1];
        end
      end
    end

    assign q = stage[n-1];
  end

endmodule

//--- hw/pixel_valid_pipe.sv
`timescale 1ns/1ps

module pixel_valid_pipe #(
  parameter int cols = 4
) (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        pixels_m_valid,
  input  logic [cols-1:0]             s_valid,
  input  logic [cols-1:0]             col_ready,
  input  pe_pkg::tuser_t [cols-1:0]   s_user,
  output logic [cols-1:0]             col_valid
);

  // pixel valid as seen by each column, one column per accepted beat
  logic [cols-1:0] pix_valid;

  for (genvar i = 0; i < cols; i++) begin : g_col
    if (i == 0) begin : g_head
      // column 0 sees the pixel source directly
      assign pix_valid[i] = pixels_m_valid;
    end else begin : g_tail
      logic pix_valid_q;

      always_ff @(posedge clk) begin
        if (!resetn) begin
          pix_valid_q <= 1'b0;
        end else if (col_ready[i-1]) begin
          // left neighbour moved its pixel on, so this column gets it
          pix_valid_q <= pix_valid[i-1];
        end else if (col_ready[i]) begin
          // this column used its pixel while nothing new came in
          pix_valid_q <= 1'b0;
        end
      end

      assign pix_valid[i] = pix_valid_q;
    end

    // a weight beat only counts once its pixel has arrived here
    assign col_valid[i] = s_valid[i] & pix_valid[i];
  end

endmodule

//--- hw/pe_column.sv
`timescale 1ns/1ps

module pe_column #(
  parameter int rows      = 4,
  parameter int x_bits    = 8,
  parameter int k_bits    = 8,
  parameter int y_bits    = 24,
  parameter int delay_mul = 3
) (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         col_en,
  input  logic                         in_valid,
  input  logic                         in_last,
  input  pe_pkg::tuser_t               in_user,
  input  logic [rows-1:0][x_bits-1:0]  pix_in,
  input  logic [k_bits-1:0]            weight,
  output logic [rows-1:0][x_bits-1:0]  pix_out,
  output logic                         col_ready,
  output logic                         acc_valid,
  output logic                         acc_last,
  output logic [rows-1:0][y_bits-1:0]  acc_data,
  input  logic                         col_release
);

  // full precision signed product
  localparam int m_bits = x_bits + k_bits;

  // multiplier input registers
  logic [rows-1:0][x_bits-1:0] pix_q;
  logic [k_bits-1:0]           weight_q;

  // products straight out of the multipliers, then after the pipeline
  logic [rows-1:0][m_bits-1:0] prod;
  logic [rows-1:0][m_bits-1:0] prod_d;

  // running sums
  logic [rows-1:0][y_bits-1:0] acc_q;

  // beat control before and after the multiplier delay
  pe_pkg::beat_ctrl_t in_ctrl;
  pe_pkg::beat_ctrl_t mul_ctrl;

  logic acc_en;
  logic first_q;
  logic bypass;
  logic acc_valid_next;

  // the multiplier pipeline only moves while the column is enabled
  assign col_ready = col_en;

  assign in_ctrl = '{valid: in_valid, last: in_last, user: in_user};

  // input registers, the pixel copy also feeds the next column
  always_ff @(posedge clk) begin
    if (col_en) begin
      pix_q    <= pix_in;
      weight_q <= weight;
    end
  end

  assign pix_out = pix_q;

  // control delayed by the full multiplier latency
  n_delay #(
    .n     (delay_mul),
    .width ($bits(pe_pkg::beat_ctrl_t))
  ) u_ctrl_delay (
    .clk    (clk),
    .resetn (resetn),
    .en     (col_en),
    .d      (in_ctrl),
    .q      (mul_ctrl)
  );

  for (genvar r = 0; r < rows; r++) begin : g_row
    // one signed multiplier per row, all sharing the column weight
    assign prod[r] = $signed(pix_q[r]) * $signed(weight_q);

    // input register is one stage, the rest of the depth lives here
    n_delay #(
      .n     (delay_mul - 1),
      .width (m_bits)
    ) u_prod_delay (
      .clk    (clk),
      .resetn (resetn),
      .en     (col_en),
      .d      (prod[r]),
      .q      (prod_d[r])
    );
  end

  // accumulate only real beats
  assign acc_en = col_en & mul_ctrl.valid;

  // start from zero after a finished sum or when the beat says so
  assign bypass = first_q | mul_ctrl.user.is_w_first;

  // the last channel closes the sum and makes the result visible
  assign acc_valid_next = mul_ctrl.valid & mul_ctrl.user.is_cin_last;

  always_ff @(posedge clk) begin
    if (acc_en) begin
      for (int r = 0; r < rows; r++) begin
        // product is sign extended into the accumulator width
        acc_q[r] <= (bypass ? '0 : acc_q[r]) + y_bits'($signed(prod_d[r]));
      end
    end
  end

  assign acc_data = acc_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      // the first sum after reset starts clean
      first_q   <= 1'b1;
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
    end else begin
      if (acc_en) begin
        first_q  <= mul_ctrl.user.is_cin_last;
        acc_last <= mul_ctrl.last;
      end
      if (col_en) begin
        // drops unless a new sum finishes in the same cycle
        acc_valid <= acc_valid_next;
      end else if (col_release) begin
        // shifter took the result while we were held by a column on the right;
        // the next beat is still waiting in the pipeline
        acc_valid <= 1'b0;
      end
    end
  end

endmodule

//--- hw/output_shifter.sv
`timescale 1ns/1ps

module output_shifter #(
  parameter int rows   = 4,
  parameter int cols   = 4,
  parameter int y_bits = 24
) (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic [cols-1:0]                       acc_valid,
  input  logic [cols-1:0]                       acc_last,
  input  logic [cols-1:0][rows-1:0][y_bits-1:0] acc_data,
  input  logic                                  m_ready,
  output logic [cols-1:0]                       col_en,
  output logic [cols-1:0]                       col_release,
  output logic [rows-1:0][y_bits-1:0]           m_data,
  output logic                                  m_valid,
  output logic                                  m_last
);

  // one slot per column, slot cols-1 drives the port
  logic [cols-1:0][rows-1:0][y_bits-1:0] slot_data;
  logic [cols-1:0]                       slot_last;
  logic [cols-1:0]                       slot_full;
  logic [cols-1:0]                       slot_flag;

  // what each slot would take from its left neighbour
  logic [cols-1:0][rows-1:0][y_bits-1:0] data_in;
  logic [cols-1:0]                       last_in;
  logic [cols-1:0]                       full_in;

  logic [cols-1:0] room;
  logic [cols-1:0] load;
  logic [cols-1:0] slot_en;
  logic [cols-1:0] freeze;

  // enable chain, runs from the rightmost column to the left
  logic [cols:0]   en_chain;

  // slot 0 has no left neighbour and fills with empty
  assign data_in = slot_data << (rows * y_bits);
  assign last_in = slot_last << 1;
  assign full_in = slot_full << 1;

  for (genvar c = 0; c < cols; c++) begin : g_col
    // a load also needs the slot to the right free, or the shift would clobber it
    if (c == cols - 1) begin : g_edge
      assign room[c] = ~slot_full[c];
    end else begin : g_inner
      assign room[c] = ~slot_full[c] & ~slot_full[c+1];
    end

    assign load[c]    = acc_valid[c] & room[c];
    assign freeze[c]  = acc_valid[c] & ~room[c];
    assign slot_en[c] = load[c] | (m_ready & slot_flag[c]);

    // column c runs only when nothing at c or to its right is frozen
    assign en_chain[c] = en_chain[c+1] & ~freeze[c];

    // result taken although the column itself is held
    assign col_release[c] = load[c] & ~col_en[c];
  end

  assign en_chain[cols] = 1'b1;
  assign col_en = en_chain[cols-1:0];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      slot_full <= '0;
      slot_flag <= '0;
      slot_last <= '0;
    end else begin
      for (int c = 0; c < cols; c++) begin
        // group is complete once the last slot fills, then drain it
        if (load[cols-1]) begin
          slot_flag[c] <= 1'b1;
        end else if (!slot_full[c]) begin
          slot_flag[c] <= 1'b0;
        end
        if (slot_en[c]) begin
          if (load[c]) begin
            slot_full[c] <= 1'b1;
            // only column 0 closes a group
            slot_last[c] <= acc_last[c] & (c == 0);
          end else begin
            slot_full[c] <= full_in[c];
            slot_last[c] <= last_in[c];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < cols; c++) begin
      if (slot_en[c]) begin
        slot_data[c] <= load[c] ? acc_data[c] : data_in[c];
      end
    end
  end

  // port is the rightmost slot, valid only while its group drains
  assign m_data  = slot_data[cols-1];
  assign m_valid = slot_full[cols-1] & slot_flag[cols-1];
  assign m_last  = slot_last[cols-1];

endmodule

//--- hw/proc_engine.sv
`timescale 1ns/1ps

module proc_engine #(
  parameter int rows      = pe_pkg::default_rows,
  parameter int cols      = pe_pkg::default_cols,
  parameter int x_bits    = pe_pkg::default_x_bits,
  parameter int k_bits    = pe_pkg::default_k_bits,
  parameter int y_bits    = pe_pkg::default_y_bits,
  parameter int delay_mul = pe_pkg::default_delay_mul
) (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic [cols-1:0]              s_valid,
  input  logic [cols-1:0]              s_last,
  input  pe_pkg::tuser_t [cols-1:0]    s_user,
  output logic [cols-1:0]              s_ready,
  input  logic [rows-1:0][x_bits-1:0]  s_data_pixels,
  input  logic [cols-1:0][k_bits-1:0]  s_data_weights,
  input  logic                         pixels_m_valid,
  input  logic                         m_ready,
  output logic [rows-1:0][y_bits-1:0]  m_data,
  output logic                         m_valid,
  output logic                         m_last
);

  // column inputs after pixel gating
  logic [cols-1:0] col_valid;
  // enable and release back from the shifter
  logic [cols-1:0] col_en;
  logic [cols-1:0] col_release;

  // results on their way to the shifter
  logic [cols-1:0]                       acc_valid;
  logic [cols-1:0]                       acc_last;
  logic [cols-1:0][rows-1:0][y_bits-1:0] acc_data;

  // pixels moving left to right, entry c feeds column c
  logic [cols-1:0][rows-1:0][x_bits-1:0] pix_chain;

  assign pix_chain[0] = s_data_pixels;

  pixel_valid_pipe #(
    .cols (cols)
  ) u_pix_valid (
    .clk            (clk),
    .resetn         (resetn),
    .pixels_m_valid (pixels_m_valid),
    .s_valid        (s_valid),
    .col_ready      (s_ready),
    .s_user         (s_user),
    .col_valid      (col_valid)
  );

  for (genvar c = 0; c < cols; c++) begin : g_col
    // the last column's pixels go nowhere
    logic [rows-1:0][x_bits-1:0] pix_next;

    if (c < cols - 1) begin : g_link
      assign pix_chain[c+1] = pix_next;
    end

    pe_column #(
      .rows      (rows),
      .x_bits    (x_bits),
      .k_bits    (k_bits),
      .y_bits    (y_bits),
      .delay_mul (delay_mul)
    ) u_column (
      .clk         (clk),
      .resetn      (resetn),
      .col_en      (col_en[c]),
      .in_valid    (col_valid[c]),
      .in_last     (s_last[c]),
      .in_user     (s_user[c]),
      .pix_in      (pix_chain[c]),
      .weight      (s_data_weights[c]),
      .pix_out     (pix_next),
      .col_ready   (s_ready[c]),
      .acc_valid   (acc_valid[c]),
      .acc_last    (acc_last[c]),
      .acc_data    (acc_data[c]),
      .col_release (col_release[c])
    );
  end

  output_shifter #(
    .rows   (rows),
    .cols   (cols),
    .y_bits (y_bits)
  ) u_shifter (
    .clk         (clk),
    .resetn      (resetn),
    .acc_valid   (acc_valid),
    .acc_last    (acc_last),
    .acc_data    (acc_data),
    .m_ready     (m_ready),
    .col_en      (col_en),
    .col_release (col_release),
    .m_data      (m_data),
    .m_valid     (m_valid),
    .m_last      (m_last)
  );

endmodule

//--- sim/proc_engine_assertions.sv
`timescale 1ns/1ps

module proc_engine_assertions #(
  parameter int rows   = 4,
  parameter int cols   = 4,
  parameter int y_bits = 24
) (
  input logic                                  clk,
  input logic                                  resetn,
  input logic [cols-1:0]                       s_ready,
  input logic [cols-1:0]                       acc_valid,
  input logic [cols-1:0][rows-1:0][y_bits-1:0] acc_data,
  input logic [rows-1:0][y_bits-1:0]           m_data,
  input logic                                  m_valid,
  input logic                                  m_ready,
  input logic                                  m_last
);

  // failed assertion count for the closing summary
  int failures = 0;

  // a stalled output beat must not change until it is taken
  property hold_under_stall;
    @(posedge clk) disable iff (!resetn)
      m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last);
  endproperty

  // synchronous reset empties the output port
  property idle_after_reset;
    @(posedge clk) !resetn |=> !m_valid;
  endproperty

  // a result stuck behind a stalled port stays in its column
  // and the whole array stays frozen
  property frozen_when_full;
    @(posedge clk) disable iff (!resetn)
      m_valid && !m_ready && acc_valid[cols-1] |=>
        acc_valid[cols-1] && $stable(acc_data[cols-1]) && s_ready == '0;
  endproperty

  assert property (hold_under_stall) else begin
    failures++;
    $error("output beat changed while the sink stalled");
  end

  assert property (idle_after_reset) else begin
    failures++;
    $error("m_valid high after a reset cycle");
  end

  assert property (frozen_when_full) else begin
    failures++;
    $error("stalled result lost or s_ready high while the output was full and stalled");
  end

endmodule

bind proc_engine proc_engine_assertions #(
  .rows   (rows),
  .cols   (cols),
  .y_bits (y_bits)
) u_assertions (
  .clk       (clk),
  .resetn    (resetn),
  .s_ready   (s_ready),
  .acc_valid (acc_valid),
  .acc_data  (acc_data),
  .m_data    (m_data),
  .m_valid   (m_valid),
  .m_ready   (m_ready),
  .m_last    (m_last)
);

//--- sim/proc_engine_tb.sv
`timescale 1ns/1ps

module proc_engine_tb;

  localparam int rows       = pe_pkg::default_rows;
  localparam int cols       = pe_pkg::default_cols;
  localparam int x_bits     = pe_pkg::default_x_bits;
  localparam int k_bits     = pe_pkg::default_k_bits;
  localparam int y_bits     = pe_pkg::default_y_bits;
  localparam int max_beats  = 64;
  localparam int step_limit = 2000;

  logic                        clk = 1'b0;
  logic                        resetn;
  logic [cols-1:0]             s_valid;
  logic [cols-1:0]             s_last;
  pe_pkg::tuser_t [cols-1:0]   s_user;
  logic [cols-1:0]             s_ready;
  logic [rows-1:0][x_bits-1:0] s_data_pixels;
  logic [cols-1:0][k_bits-1:0] s_data_weights;
  logic                        pixels_m_valid;
  logic                        m_ready;
  logic [rows-1:0][y_bits-1:0] m_data;
  logic                        m_valid;
  logic                        m_last;

  // beat stream shared by all columns
  // column c sees beat k c cycles later
  logic [x_bits-1:0] pix_mem [max_beats][rows];
  logic [k_bits-1:0] w_mem [max_beats][cols];
  logic              first_mem [max_beats];
  logic              cin_last_mem [max_beats];
  logic              last_mem [max_beats];
  int                n_beats;

  // expected results in port order
  logic [rows-1:0][y_bits-1:0] exp_data [$];
  logic                        exp_last [$];

  logic [31:0] lcg_state = 32'h8b66;
  bit          ready_random;
  int          test_errors;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  proc_engine #(
    .rows      (rows),
    .cols      (cols),
    .x_bits    (x_bits),
    .k_bits    (k_bits),
    .y_bits    (y_bits),
    .delay_mul (pe_pkg::default_delay_mul)
  ) dut (
    .clk            (clk),
    .resetn         (resetn),
    .s_valid        (s_valid),
    .s_last         (s_last),
    .s_user         (s_user),
    .s_ready        (s_ready),
    .s_data_pixels  (s_data_pixels),
    .s_data_weights (s_data_weights),
    .pixels_m_valid (pixels_m_valid),
    .m_ready        (m_ready),
    .m_data         (m_data),
    .m_valid        (m_valid),
    .m_last         (m_last)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // fill the beat memories and derive every column's sums from them
  // lead beats form a sum that never closes and must be discarded
  task automatic build_stream(input int lead, input int sum_len, input int n_sums,
                              input bit extremes);
    logic [31:0]                 rnd;
    logic [rows-1:0][y_bits-1:0] res [cols];
    int                          sum_acc [cols][rows];
    int                          p;
    int                          w;
    int                          base;
    n_beats = lead + sum_len * n_sums;
    for (int k = 0; k < n_beats; k++) begin
      // only the first full sum is marked
      // later sums start after is_cin_last
      first_mem[k]    = k == lead;
      cin_last_mem[k] = (k >= lead) && ((k - lead) % sum_len == sum_len - 1);
      // packet end on the final beat of the stream
      last_mem[k]     = k == n_beats - 1;
      for (int r = 0; r < rows; r++) begin
        rnd = next_random();
        pix_mem[k][r] = extremes ? 8'h80 : rnd[23:16];
      end
      for (int c = 0; c < cols; c++) begin
        rnd = next_random();
        // most negative weight mixed with the most positive one
        w_mem[k][c] = extremes ? (rnd[20] ? 8'h80 : 8'h7f) : rnd[23:16];
      end
    end
    for (int j = 0; j < n_sums; j++) begin
      base = lead + j * sum_len;
      for (int c = 0; c < cols; c++) begin
        for (int r = 0; r < rows; r++) begin
          sum_acc[c][r] = 0;
          for (int k = base; k < base + sum_len; k++) begin
            p = $signed(pix_mem[k][r]);
            w = $signed(w_mem[k][c]);
            sum_acc[c][r] += p * w;
          end
          res[c][r] = y_bits'(sum_acc[c][r]);
        end
      end
      // a group leaves the port rightmost column first
      for (int c = cols - 1; c >= 0; c--) begin
        exp_data.push_back(res[c]);
        // only the final group of the stream carries last
        exp_last.push_back((c == 0) && (j == n_sums - 1));
      end
    end
  endtask

  // present each column's next beat, or nothing once its stream is done
  task automatic drive_beats(input int ptr [cols]);
    logic [31:0] rnd;
    for (int c = 0; c < cols; c++) begin
      if (ptr[c] < n_beats) begin
        s_valid[c]            = 1'b1;
        s_last[c]             = last_mem[ptr[c]];
        s_user[c].is_w_first  = first_mem[ptr[c]];
        s_user[c].is_cin_last = cin_last_mem[ptr[c]];
        s_data_weights[c]     = w_mem[ptr[c]][c];
      end else begin
        s_valid[c]        = 1'b0;
        s_last[c]         = 1'b0;
        s_user[c]         = '0;
        s_data_weights[c] = '0;
      end
    end
    // pixels enter column 0 only
    pixels_m_valid = ptr[0] < n_beats;
    for (int r = 0; r < rows; r++) begin
      s_data_pixels[r] = (ptr[0] < n_beats) ? pix_mem[ptr[0]][r] : '0;
    end
    rnd = next_random();
    m_ready = ready_random ? rnd[18] : 1'b1;
  endtask

  task automatic check_output(input string name);
    logic [rows-1:0][y_bits-1:0] want;
    logic                        want_last;
    if (exp_data.size() == 0) begin
      $display("%s: output beat appeared with no result outstanding", name);
      test_errors++;
    end else begin
      want      = exp_data.pop_front();
      want_last = exp_last.pop_front();
      for (int r = 0; r < rows; r++) begin
        if (m_data[r] !== want[r]) begin
          $display("[FAIL] %s row %0d expected %h actual %h", name, r, want[r], m_data[r]);
          test_errors++;
        end
      end
      if (m_last !== want_last) begin
        $display("[FAIL] %s m_last expected %b actual %b", name, want_last, m_last);
        test_errors++;
      end
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("%s finished with %0d errors", name, test_errors);
    end
  endtask

  // run the prepared stream until every beat is taken and every result seen
  task automatic run_stream(input string name);
    int ptr [cols];
    bit accept [cols];
    int steps;
    bit done;
    test_errors = 0;
    steps = 0;
    done = 1'b0;
    for (int c = 0; c < cols; c++) begin
      ptr[c] = 0;
    end
    while (!done && steps < step_limit) begin
      @(negedge clk);
      drive_beats(ptr);
      // inputs and outputs are settled well before the rising edge
      #5;
      for (int c = 0; c < cols; c++) begin
        accept[c] = (ptr[c] < n_beats) && dut.col_valid[c] && s_ready[c];
      end
      if (m_valid && m_ready) begin
        check_output(name);
      end
      done = exp_data.size() == 0;
      for (int c = 0; c < cols; c++) begin
        if (accept[c]) begin
          ptr[c]++;
        end
        if (ptr[c] < n_beats) begin
          done = 1'b0;
        end
      end
      steps++;
    end
    if (!done) begin
      $display("%s timed out with %0d results still missing", name, exp_data.size());
      $display("Test failed");
      $finish;
    end else begin
      report_test(name);
    end
  endtask

  initial begin
    resetn         = 1'b0;
    s_valid        = '0;
    s_last         = '0;
    s_user         = '0;
    s_data_pixels  = '0;
    s_data_weights = '0;
    pixels_m_valid = 1'b0;
    m_ready        = 1'b1;
    ready_random   = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    // idle engine straight after reset
    test_errors = 0;
    @(negedge clk);
    #5;
    if (m_valid !== 1'b0) begin
      $display("[FAIL] reset_state m_valid expected 0 actual %b", m_valid);
      test_errors++;
    end
    if (s_ready !== '1) begin
      $display("[FAIL] reset_state s_ready expected %h actual %h", {cols{1'b1}}, s_ready);
      test_errors++;
    end
    report_test("reset_state");

    build_stream(0, 4, 1, 1'b0);
    run_stream("single_sum");

    // an unfinished sum ahead of the stream has to be dropped
    build_stream(3, 5, 2, 1'b0);
    run_stream("back_to_back");

    // short sums so results pile up behind a stalled port
    ready_random = 1'b1;
    build_stream(0, 2, 6, 1'b0);
    run_stream("random_backpressure");
    ready_random = 1'b0;

    build_stream(0, 3, 2, 1'b1);
    run_stream("signed_extremes");

    total_errors += dut.u_assertions.failures;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, dut.u_assertions.failures);
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- proc_engine.f
hw/pe_pkg.sv
hw/n_delay.sv
hw/pixel_valid_pipe.sv
hw/pe_column.sv
hw/output_shifter.sv
hw/proc_engine.sv
sim/proc_engine_assertions.sv
sim/proc_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f proc_engine.f --top-module proc_engine_tb -o proc_engine_sim

out=$(./obj_dir/proc_engine_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
